// ==== verilog/lc3b_cache_pkg.sv ====
`default_nettype none

package lc3b_cache_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Cache geometry.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int c_tag_width    = 9;
  localparam int c_index_width  = 3;
  localparam int c_offset_width = 4;   // 16 bytes per line.
  localparam int c_num_sets     = 8;
  localparam int c_ways         = 2;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Word, line and address field types.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef logic [15:0]  lc3b_word;
  typedef logic [1:0]   lc3b_mem_wmask;
  typedef logic [127:0] lc3b_c_line;   // Eight words.

  // Address splits into tag, index and offset from the top down.
  typedef logic [c_tag_width-1:0]    lc3b_c_tag;
  typedef logic [c_index_width-1:0]  lc3b_c_index;
  typedef logic [c_offset_width-1:0] lc3b_c_offset;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Controller states.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef enum logic [1:0] {
    s_idle,
    s_hit,
    s_writeback,
    s_fill
  } cache_state_t;

endpackage

`default_nettype wire

// ==== verilog/cache_array.sv ====
`timescale 1ns/1ps
`default_nettype none

// One entry per set. Read is combinational, write lands at the edge.
module cache_array
  import lc3b_cache_pkg::*;
#(
  parameter int width = 1
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             write,
  input  lc3b_c_index      index,
  input  logic [width-1:0] datain,
  output logic [width-1:0] dataout
);

  logic [width-1:0] entries [c_num_sets];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < c_num_sets; i++) begin
        entries[i] <= '0;   // Valid, dirty and LRU start cleared.
      end
    end else if (write) begin
      entries[index] <= datain;
    end
  end

  assign dataout = entries[index];

endmodule

`default_nettype wire

// ==== verilog/cache_ctrl_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface cache_ctrl_if;

  // Controller to datapath.
  logic load_line;     // Fill victim way from memory.
  logic load_word;     // Merge processor word into hit way.
  logic touch_lru;
  logic addr_sel_wb;   // Victim tag on the memory address.

  // Datapath to controller.
  logic hit;
  logic victim_dirty;

  modport ctrl (
    output load_line, load_word, touch_lru, addr_sel_wb,
    input  hit, victim_dirty
  );

  modport dp (
    input  load_line, load_word, touch_lru, addr_sel_wb,
    output hit, victim_dirty
  );

endinterface

`default_nettype wire

// ==== verilog/cache_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_datapath
  import lc3b_cache_pkg::*;
(
  input  logic          clk,
  input  logic          rst_n,
  input  lc3b_word      address,
  input  lc3b_word      wdata,
  input  lc3b_mem_wmask wmask,
  input  lc3b_c_line    pmem_rdata,
  cache_ctrl_if.dp      ctrl,
  output lc3b_word      rdata,
  output lc3b_word      pmem_address,
  output lc3b_c_line    pmem_wdata
);

  lc3b_c_tag    tag;
  lc3b_c_index  index;
  lc3b_c_offset offset;
  logic [2:0]   word_sel;

  lc3b_c_line        data_out [c_ways];
  lc3b_c_tag         tag_out [c_ways];
  logic [c_ways-1:0] valid_out;
  logic [c_ways-1:0] dirty_out;
  logic [c_ways-1:0] way_hit;

  logic       hit_way;
  logic       victim;
  lc3b_c_tag  victim_tag;
  lc3b_c_line hit_line;
  lc3b_c_line merged_line;
  lc3b_c_line line_in;

  assign {tag, index, offset} = address;
  assign word_sel = offset[3:1];   // Byte bit goes through wmask only.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Hit detection and read path.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign ctrl.hit = |way_hit;
  assign hit_way  = way_hit[1];
  assign hit_line = hit_way ? data_out[1] : data_out[0];
  assign rdata    = hit_line[16*word_sel +: 16];

  // Enabled bytes replace the addressed word.
  always_comb begin
    merged_line = hit_line;
    if (wmask[0]) begin
      merged_line[16*word_sel +: 8] = wdata[7:0];
    end
    if (wmask[1]) begin
      merged_line[16*word_sel + 8 +: 8] = wdata[15:8];
    end
  end

  assign line_in = ctrl.load_line ? pmem_rdata : merged_line;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Replacement and write-back.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  cache_array #(.width(1)) lru_array (
    .clk     (clk),
    .rst_n   (rst_n),
    .write   (ctrl.touch_lru),
    .index   (index),
    .datain  (~hit_way),   // Other way becomes LRU.
    .dataout (victim)
  );

  assign victim_tag        = tag_out[victim];
  assign ctrl.victim_dirty = valid_out[victim] & dirty_out[victim];
  assign pmem_wdata        = data_out[victim];

  assign pmem_address = ctrl.addr_sel_wb ? {victim_tag, index, {c_offset_width{1'b0}}}
                                         : {tag, index, {c_offset_width{1'b0}}};

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Per-way storage.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  for (genvar w = 0; w < c_ways; w++) begin : g_way
    logic fill_we;
    logic data_we;

    assign fill_we    = ctrl.load_line && (victim == 1'(w));
    assign data_we    = fill_we || (ctrl.load_word && way_hit[w]);
    assign way_hit[w] = valid_out[w] && (tag_out[w] == tag);

    cache_array #(.width($bits(lc3b_c_line))) data_array (
      .clk     (clk),
      .rst_n   (rst_n),
      .write   (data_we),
      .index   (index),
      .datain  (line_in),
      .dataout (data_out[w])
    );

    cache_array #(.width(c_tag_width)) tag_array (
      .clk     (clk),
      .rst_n   (rst_n),
      .write   (fill_we),
      .index   (index),
      .datain  (tag),
      .dataout (tag_out[w])
    );

    cache_array #(.width(1)) valid_array (
      .clk     (clk),
      .rst_n   (rst_n),
      .write   (fill_we),
      .index   (index),
      .datain  (1'b1),
      .dataout (valid_out[w])
    );

    // Set by a word merge, cleared by a fill.
    cache_array #(.width(1)) dirty_array (
      .clk     (clk),
      .rst_n   (rst_n),
      .write   (data_we),
      .index   (index),
      .datain  (ctrl.load_word),
      .dataout (dirty_out[w])
    );
  end

  // A fill never duplicates a line already resident in the other way.
  a_one_way_hit: assert property (@(posedge clk) disable iff (!rst_n)
    !(way_hit[0] && way_hit[1]));

endmodule

`default_nettype wire

// ==== verilog/cache_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_control
  import lc3b_cache_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       mem_read,
  input  logic       mem_write,
  input  logic       pmem_resp,
  cache_ctrl_if.ctrl ctrl,
  output logic       mem_resp,
  output logic       pmem_read,
  output logic       pmem_write
);

  cache_state_t state;
  cache_state_t state_next;
  logic         request;

  assign request = mem_read | mem_write;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= s_idle;
    end else begin
      state <= state_next;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Next state and outputs.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    state_next       = state;
    mem_resp         = 1'b0;
    pmem_read        = 1'b0;
    pmem_write       = 1'b0;
    ctrl.load_line   = 1'b0;
    ctrl.load_word   = 1'b0;
    ctrl.touch_lru   = 1'b0;
    ctrl.addr_sel_wb = 1'b0;

    unique case (state)
      s_idle: begin
        if (request) begin
          if (ctrl.hit) begin
            state_next = s_hit;
          end else if (ctrl.victim_dirty) begin
            state_next = s_writeback;
          end else begin
            state_next = s_fill;
          end
        end
      end

      s_hit: begin
        mem_resp       = 1'b1;        // Read data valid now.
        ctrl.load_word = mem_write;
        ctrl.touch_lru = 1'b1;
        state_next     = s_idle;
      end

      s_writeback: begin
        pmem_write       = 1'b1;
        ctrl.addr_sel_wb = 1'b1;      // Victim line address.
        if (pmem_resp) begin
          state_next = s_fill;
        end
      end

      s_fill: begin
        pmem_read      = 1'b1;
        ctrl.load_line = pmem_resp;   // Line lands with the response.
        if (pmem_resp) begin
          state_next = s_hit;
        end
      end

      default: state_next = s_idle;
    endcase
  end

  a_pmem_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(pmem_read && pmem_write));

  // Response comes one cycle after a hit in idle or a completed fill.
  a_resp_after_hit: assert property (@(posedge clk) disable iff (!rst_n)
    mem_resp |-> (($past(state) == s_idle) && $past(request))
              || (($past(state) == s_fill) && $past(pmem_resp)));

endmodule

`default_nettype wire

// ==== verilog/cache.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache
  import lc3b_cache_pkg::*;
(
  input  logic          clk,
  input  logic          rst_n,

  // Processor side.
  input  lc3b_word      mem_address,
  input  logic          mem_read,
  input  logic          mem_write,
  input  lc3b_word      mem_wdata,
  input  lc3b_mem_wmask mem_wmask,
  output lc3b_word      mem_rdata,
  output logic          mem_resp,

  // Physical memory side.
  output lc3b_word      pmem_address,
  output logic          pmem_read,
  output logic          pmem_write,
  output lc3b_c_line    pmem_wdata,
  input  lc3b_c_line    pmem_rdata,
  input  logic          pmem_resp
);

  cache_ctrl_if ctrl_if ();

  cache_control control_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .mem_read   (mem_read),
    .mem_write  (mem_write),
    .pmem_resp  (pmem_resp),
    .ctrl       (ctrl_if.ctrl),
    .mem_resp   (mem_resp),
    .pmem_read  (pmem_read),
    .pmem_write (pmem_write)
  );

  cache_datapath datapath_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .address      (mem_address),
    .wdata        (mem_wdata),
    .wmask        (mem_wmask),
    .pmem_rdata   (pmem_rdata),
    .ctrl         (ctrl_if.dp),
    .rdata        (mem_rdata),
    .pmem_address (pmem_address),
    .pmem_wdata   (pmem_wdata)
  );

endmodule

`default_nettype wire

// ==== verification/cache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_tb
  import lc3b_cache_pkg::*;
();

  logic          clk;
  logic          rst_n;
  lc3b_word      mem_address;
  logic          mem_read;
  logic          mem_write;
  lc3b_word      mem_wdata;
  lc3b_mem_wmask mem_wmask;
  lc3b_word      mem_rdata;
  logic          mem_resp;
  lc3b_word      pmem_address;
  logic          pmem_read;
  logic          pmem_write;
  lc3b_c_line    pmem_wdata;
  lc3b_c_line    pmem_rdata;
  logic          pmem_resp;

  lc3b_c_line mem_lines [lc3b_word];   // Lines written back so far.
  lc3b_word   shadow [lc3b_word];      // Words the processor wrote.
  logic       log_write [$];
  lc3b_word   log_addr [$];
  lc3b_c_line log_wdata [$];
  int         errors;
  int         tests_passed;
  int         tests_failed;
  int         last_latency;
  lc3b_word   addr_a;
  lc3b_word   addr_b;
  lc3b_word   addr_c;
  lc3b_word   addr_d;

  cache cache_i (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Reference model.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic lc3b_word rule_word(input lc3b_word addr);
    return {addr[15:1], 1'b0} ^ 16'hA5A5;
  endfunction

  function automatic lc3b_word expected_word(input lc3b_word addr);
    lc3b_word a;
    a = {addr[15:1], 1'b0};
    return shadow.exists(a) ? shadow[a] : rule_word(a);
  endfunction

  function automatic lc3b_word line_base(input lc3b_word addr);
    return {addr[15:4], 4'h0};
  endfunction

  function automatic lc3b_c_line model_line(input lc3b_word base);
    lc3b_c_line line;
    for (int i = 0; i < 8; i++) begin
      line[16*i +: 16] = rule_word(base + 16'(2 * i));
    end
    return line;
  endfunction

  function automatic lc3b_c_line expected_line(input lc3b_word base);
    lc3b_c_line line;
    for (int i = 0; i < 8; i++) begin
      line[16*i +: 16] = expected_word(base + 16'(2 * i));
    end
    return line;
  endfunction

  // Physical memory answers after 0 to 4 idle cycles.
  initial begin
    lc3b_word addr;
    int       delay;
    pmem_resp  = 1'b0;
    pmem_rdata = '0;
    void'($urandom(17));
    forever begin
      @(negedge clk);
      if (rst_n && (pmem_read || pmem_write)) begin
        addr  = pmem_address;
        delay = $urandom % 5;
        log_write.push_back(pmem_write);
        log_addr.push_back(addr);
        if (pmem_write) begin
          log_wdata.push_back(pmem_wdata);
          mem_lines[addr] = pmem_wdata;
        end
        repeat (delay) @(posedge clk);
        @(posedge clk);
        #2;
        pmem_rdata = mem_lines.exists(addr) ? mem_lines[addr] : model_line(addr);
        pmem_resp  = 1'b1;
        @(posedge clk);
        #2;
        pmem_resp = 1'b0;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Checks.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic compare_word(input string name, input lc3b_word exp, input lc3b_word act);
    if (exp !== act) begin
      $display("** Error at %0t ns: %s expected %h, actual %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic compare_line(input string name, input lc3b_c_line exp,
                              input lc3b_c_line act);
    if (exp !== act) begin
      $display("** Error at %0t ns: %s expected %h, actual %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic compare_addr(input string name, input lc3b_word exp, input lc3b_word act);
    if (exp !== act) begin
      $display("** Error at %0t ns: %s expected %h, actual %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_that(input bit cond, input string what);
    if (!cond) begin
      $display("Failure at %0t ns: %s", $time, what);
      errors++;
    end
  endtask

  task automatic clear_log();
    log_write.delete();
    log_addr.delete();
    log_wdata.delete();
  endtask

  // Checks that the log holds one fill of the given line and nothing else.
  task automatic expect_single_fill(input lc3b_word addr);
    check_that(log_write.size() == 1 && log_write[0] == 1'b0,
               "miss did not cause exactly one pmem_read and no pmem_write");
    if (log_addr.size() == 1) begin
      compare_addr("pmem_address", line_base(addr), log_addr[0]);
    end
  endtask

  task automatic finish_test(input string name, input int errors_before);
    if (errors == errors_before) begin
      tests_passed++;
      $display("%s: passed", name);
    end else begin
      tests_failed++;
      $display("%s: failed", name);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Processor accesses.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic cpu_access(input logic wr, input lc3b_word addr, input lc3b_word wdata,
                            input lc3b_mem_wmask mask, output lc3b_word rdata);
    int cycles;
    cycles = 0;
    @(posedge clk);
    #2;
    mem_address = addr;
    mem_read    = ~wr;
    mem_write   = wr;
    mem_wdata   = wdata;
    mem_wmask   = mask;
    do begin
      @(negedge clk);
      cycles++;
      if (cycles > 200) begin
        $display("Timeout: no mem_resp for address %h within 200 cycles", addr);
        $display("TEST FAIL");
        $finish;
      end
    end while (!mem_resp);
    rdata        = mem_rdata;
    last_latency = cycles - 1;   // Edges after the one that saw the request.
    @(posedge clk);
    #2;
    mem_read  = 1'b0;
    mem_write = 1'b0;
  endtask

  task automatic cpu_read(input lc3b_word addr);
    lc3b_word data;
    cpu_access(1'b0, addr, 16'h0000, 2'b11, data);
    compare_word("mem_rdata", expected_word(addr), data);
  endtask

  task automatic cpu_write(input lc3b_word addr, input lc3b_word data,
                           input lc3b_mem_wmask mask);
    lc3b_word merged;
    lc3b_word unused;
    merged = expected_word(addr);
    if (mask[0]) begin
      merged[7:0] = data[7:0];
    end
    if (mask[1]) begin
      merged[15:8] = data[15:8];
    end
    cpu_access(1'b1, addr, data, mask, unused);
    shadow[{addr[15:1], 1'b0}] = merged;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Directed tests in set 2.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic test_cold_read_miss();
    int e;
    e = errors;
    clear_log();
    cpu_read(addr_a);
    expect_single_fill(addr_a);
    finish_test("cold read miss", e);
  endtask

  task automatic test_read_hit();
    int e;
    e = errors;
    clear_log();
    cpu_read({addr_a[15:4], 4'hA});
    check_that(log_write.size() == 0, "read hit caused pmem activity");
    check_that(last_latency == 1, "read hit mem_resp not one cycle after request");
    finish_test("read hit", e);
  endtask

  task automatic test_byte_writes();
    int e;
    e = errors;
    clear_log();
    cpu_write(addr_a, 16'h1234, 2'b11);
    cpu_read(addr_a);
    cpu_write(addr_a, 16'hBEEF, 2'b01);
    cpu_read(addr_a);
    cpu_write(addr_a, 16'hC0DE, 2'b10);
    cpu_read(addr_a);
    check_that(log_write.size() == 0, "write hit caused pmem activity");
    finish_test("byte-masked write", e);
  endtask

  task automatic test_two_ways();
    int e;
    e = errors;
    cpu_read(addr_b);   // Fills the second way.
    clear_log();
    for (int i = 0; i < 2; i++) begin
      cpu_read(addr_a);
      cpu_read(addr_b);
    end
    check_that(log_write.size() == 0, "alternating reads in one set caused pmem activity");
    finish_test("two ways per set", e);
  endtask

  task automatic test_dirty_eviction();
    int         e;
    lc3b_c_line exp_line;
    e = errors;
    cpu_write({addr_a[15:4], 4'h8}, 16'h5A5A, 2'b11);
    cpu_read(addr_b);
    exp_line = expected_line(line_base(addr_a));
    clear_log();
    cpu_read(addr_c);
    check_that(log_write.size() == 2 && log_write[0] == 1'b1 && log_write[1] == 1'b0,
               "dirty miss was not one pmem_write followed by one pmem_read");
    if (log_addr.size() == 2 && log_wdata.size() == 1) begin
      compare_addr("pmem_address", line_base(addr_a), log_addr[0]);
      compare_line("pmem_wdata", exp_line, log_wdata[0]);
      compare_addr("pmem_address", line_base(addr_c), log_addr[1]);
    end
    finish_test("dirty eviction", e);
  endtask

  task automatic test_clean_eviction();
    int e;
    e = errors;
    clear_log();
    cpu_read(addr_d);
    expect_single_fill(addr_d);
    clear_log();
    cpu_read(addr_b);
    expect_single_fill(addr_b);
    clear_log();
    cpu_read(addr_a);   // Comes back from the written-back line.
    expect_single_fill(addr_a);
    finish_test("clean eviction", e);
  endtask

  initial begin
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    last_latency = 0;
    rst_n        = 1'b0;
    mem_address  = '0;
    mem_read     = 1'b0;
    mem_write    = 1'b0;
    mem_wdata    = '0;
    mem_wmask    = '0;
    addr_a       = {9'h012, 3'd2, 4'h6};
    addr_b       = {9'h034, 3'd2, 4'h2};
    addr_c       = {9'h056, 3'd2, 4'h0};
    addr_d       = {9'h078, 3'd2, 4'h4};
    repeat (2) @(posedge clk);
    #2;
    rst_n = 1'b1;

    test_cold_read_miss();
    test_read_hit();
    test_byte_writes();
    test_two_ways();
    test_dirty_eviction();
    test_clean_eviction();

    $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
verilog/lc3b_cache_pkg.sv
verilog/cache_array.sv
verilog/cache_ctrl_if.sv
verilog/cache_datapath.sv
verilog/cache_control.sv
verilog/cache.sv
verification/cache_tb.sv

// ==== Bender.yml ====
package:
  name: lc3b_cache

sources:
  - verilog/lc3b_cache_pkg.sv
  - verilog/cache_array.sv
  - verilog/cache_ctrl_if.sv
  - verilog/cache_datapath.sv
  - verilog/cache_control.sv
  - verilog/cache.sv
  - target: test
    files:
      - verification/cache_tb.sv
